/* flist.f */
logic/exe_pkg.sv
logic/exe_operand_sel.sv
logic/exe_alu.sv
logic/exe_mul_unit.sv
logic/exe_branch_unit.sv
logic/exe_writeback_sel.sv
logic/exe_stage.sv
verification/exe_stage_sva.sv
verification/exe_stage_tb.sv

/* Makefile */
TOP := exe_stage_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* verification/exe_stage_tb.sv */
// Execute stage testbench: table of instructions with expected write-back outputs
`default_nettype none

module exe_stage_tb import exe_pkg::*;;

    localparam int XLEN       = 32;
    localparam int N_ROWS     = 31;
    localparam int MAX_CYCLES = 8 + N_ROWS * (XLEN + 4);

    typedef struct packed {
        unit_t       unit;
        op_t         op;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] pc;
        logic [31:0] imm;
        logic        use_pc;
        logic        use_imm;
        logic        wb_valid;
        reg_addr_t   wb_rd;
        logic [31:0] wb_data;
        logic        ex_valid;
        cause_t      ex_cause;
        logic        irq;
        cause_t      irq_cause;
        logic [7:0]  kill_at;     // Cycles into a MUL before kill, 0 for none
        logic [31:0] e_result;
        logic [31:0] e_pc;
        logic        e_taken;
        logic        e_ex_valid;
        cause_t      e_ex_cause;
        logic [31:0] e_ex_origin;
    } row_t;

    logic clk_i;
    logic rst_n_i;
    logic kill_i;
    logic valid_i;
    unit_t unit_i;
    op_t op_i;
    reg_addr_t rs1_i;
    reg_addr_t rs2_i;
    reg_addr_t rd_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] rs2_data_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] imm_i;
    logic use_pc_i;
    logic use_imm_i;
    logic ex_valid_i;
    cause_t ex_cause_i;
    logic wb_valid_i;
    reg_addr_t wb_rd_i;
    logic [XLEN-1:0] wb_data_i;
    logic interrupt_i;
    cause_t interrupt_cause_i;
    logic valid_o;
    reg_addr_t rd_o;
    logic [XLEN-1:0] result_o;
    logic [XLEN-1:0] result_pc_o;
    logic branch_taken_o;
    logic ex_valid_o;
    cause_t ex_cause_o;
    logic [XLEN-1:0] ex_origin_o;
    logic stall_o;

    row_t tbl[$];
    row_t r;
    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    integer seed = 45;

    exe_stage #(.XLEN(XLEN)) dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Watchdog on the whole run
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // ----------------------------------------
    // Table building and driving
    // ----------------------------------------
    task automatic stim(input unit_t u, input op_t o, input reg_addr_t a, input reg_addr_t b,
                        input logic [31:0] da, input logic [31:0] db,
                        input logic [31:0] pcv, input logic [31:0] immv,
                        input logic upc, input logic uimm);
        r = '0;
        r.unit = u;
        r.op = o;
        r.rs1 = a;
        r.rs2 = b;
        r.rs1_data = da;
        r.rs2_data = db;
        r.pc = pcv;
        r.imm = immv;
        r.use_pc = upc;
        r.use_imm = uimm;
    endtask

    task automatic expect_out(input logic [31:0] res, input logic [31:0] npc, input logic tk,
                              input logic exv, input cause_t c, input logic [31:0] org);
        r.e_result = res;
        r.e_pc = npc;
        r.e_taken = tk;
        r.e_ex_valid = exv;
        r.e_ex_cause = c;
        r.e_ex_origin = org;
        tbl.push_back(r);
    endtask

    task automatic drive_idle();
        kill_i = 1'b0;
        valid_i = 1'b0;
        unit_i = UNIT_ALU;
        op_i = OP_ADD;
        rs1_i = '0;
        rs2_i = '0;
        rd_i = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        pc_i = '0;
        imm_i = '0;
        use_pc_i = 1'b0;
        use_imm_i = 1'b0;
        ex_valid_i = 1'b0;
        ex_cause_i = '0;
        wb_valid_i = 1'b0;
        wb_rd_i = '0;
        wb_data_i = '0;
        interrupt_i = 1'b0;
        interrupt_cause_i = '0;
    endtask

    task automatic apply_row(input int idx, input row_t rw);
        valid_i = 1'b1;
        kill_i = 1'b0;
        unit_i = rw.unit;
        op_i = rw.op;
        rs1_i = rw.rs1;
        rs2_i = rw.rs2;
        rd_i = 5'(idx + 1);
        rs1_data_i = rw.rs1_data;
        rs2_data_i = rw.rs2_data;
        pc_i = rw.pc;
        imm_i = rw.imm;
        use_pc_i = rw.use_pc;
        use_imm_i = rw.use_imm;
        wb_valid_i = rw.wb_valid;
        wb_rd_i = rw.wb_rd;
        wb_data_i = rw.wb_data;
        ex_valid_i = rw.ex_valid;
        ex_cause_i = rw.ex_cause;
        interrupt_i = rw.irq;
        interrupt_cause_i = rw.irq_cause;
    endtask

    task automatic value_mismatch(input int idx, input string what,
                                  input logic [31:0] got, input logic [31:0] exp);
        $display("Fail at %0t: row %0d %s is %h, expected %h", $time, idx, what, got, exp);
        value_errors++;
    endtask

    task automatic check_outputs(input int idx, input row_t rw);
        if (result_o !== rw.e_result)
            value_mismatch(idx, "result_o", result_o, rw.e_result);
        if (result_pc_o !== rw.e_pc)
            value_mismatch(idx, "result_pc_o", result_pc_o, rw.e_pc);
        if (branch_taken_o !== rw.e_taken)
            value_mismatch(idx, "branch_taken_o", 32'(branch_taken_o), 32'(rw.e_taken));
        if (ex_valid_o !== rw.e_ex_valid)
            value_mismatch(idx, "ex_valid_o", 32'(ex_valid_o), 32'(rw.e_ex_valid));
        if (ex_cause_o !== rw.e_ex_cause)
            value_mismatch(idx, "ex_cause_o", 32'(ex_cause_o), 32'(rw.e_ex_cause));
        if (ex_origin_o !== rw.e_ex_origin)
            value_mismatch(idx, "ex_origin_o", ex_origin_o, rw.e_ex_origin);
        if (valid_o !== 1'b1)
            value_mismatch(idx, "valid_o", 32'(valid_o), 32'd1);
        if (rd_o !== rd_i)
            value_mismatch(idx, "rd_o", 32'(rd_o), 32'(rd_i));
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] prod;
        int stalls;
        int exp_stalls;

        drive_idle();
        rst_n_i = 1'b0;

        // ALU with register operands
        stim(UNIT_ALU, OP_ADD, 5'd1, 5'd2, 32'd5, 32'd7, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'd12, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_SUB, 5'd1, 5'd2, 32'd5, 32'd7, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'hFFFF_FFFE, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_AND, 5'd1, 5'd2, 32'hF0F0, 32'hFF00, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'hF000, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_OR, 5'd1, 5'd2, 32'hF0F0, 32'hFF00, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'hFFF0, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_XOR, 5'd1, 5'd2, 32'hF0F0, 32'hFF00, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'h0FF0, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_SLL, 5'd1, 5'd2, 32'd1, 32'd33, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'd2, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);  // Shift by 33 mod 32
        stim(UNIT_ALU, OP_SRL, 5'd1, 5'd2, 32'h8000_0000, 32'd4, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'h0800_0000, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_SRA, 5'd1, 5'd2, 32'h8000_0000, 32'd4, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'hF800_0000, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_SLT, 5'd1, 5'd2, 32'hFFFF_FFFF, 32'd1, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'd1, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_SLTU, 5'd1, 5'd2, 32'hFFFF_FFFF, 32'd1, 32'h0, 32'h0, 1'b0, 1'b0);
        expect_out(32'd0, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);

        // PC and immediate substitution
        stim(UNIT_ALU, OP_ADD, 5'd1, 5'd2, 32'd9, 32'd9, 32'h1000, 32'h20, 1'b1, 1'b1);
        expect_out(32'h1020, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_ADD, 5'd1, 5'd2, 32'd100, 32'd9, 32'h0, 32'hFFFF_FFFC, 1'b0, 1'b1);
        expect_out(32'd96, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);

        // ----------------------------------------
        // Forwarding
        // ----------------------------------------
        stim(UNIT_SYSTEM, OP_ADD, 5'd3, 5'd0, 32'h11, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        r.wb_valid = 1'b1;
        r.wb_rd = 5'd3;
        r.wb_data = 32'hABCD;
        expect_out(32'hABCD, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_SYSTEM, OP_ADD, 5'd0, 5'd0, 32'h55, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        r.wb_valid = 1'b1;
        r.wb_data = 32'hABCD;                  // Write-back to x0 is ignored
        expect_out(32'h55, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_SYSTEM, OP_ADD, 5'd3, 5'd0, 32'h11, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        r.wb_rd = 5'd3;
        r.wb_data = 32'hABCD;
        expect_out(32'h11, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_ALU, OP_ADD, 5'd1, 5'd4, 32'd10, 32'd1, 32'h0, 32'h0, 1'b0, 1'b0);
        r.wb_valid = 1'b1;
        r.wb_rd = 5'd4;
        r.wb_data = 32'd20;
        expect_out(32'd30, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);

        // Branches at pc 0x100 with offset 0x40
        stim(UNIT_BRANCH, OP_BEQ, 5'd1, 5'd2, 32'h33, 32'h33, 32'h100, 32'h40, 1'b0, 1'b0);
        expect_out(32'h104, 32'h140, 1'b1, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_BRANCH, OP_BEQ, 5'd1, 5'd2, 32'h33, 32'h34, 32'h100, 32'h40, 1'b0, 1'b0);
        expect_out(32'h104, 32'h104, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_BRANCH, OP_BNE, 5'd1, 5'd2, 32'h33, 32'h34, 32'h100, 32'h40, 1'b0, 1'b0);
        expect_out(32'h104, 32'h140, 1'b1, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_BRANCH, OP_BLT, 5'd1, 5'd2, 32'hFFFF_FFFB, 32'd3, 32'h100, 32'h40, 1'b0, 1'b0);
        expect_out(32'h104, 32'h140, 1'b1, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_BRANCH, OP_BGE, 5'd1, 5'd2, 32'hFFFF_FFFB, 32'd3, 32'h100, 32'h40, 1'b0, 1'b0);
        expect_out(32'h104, 32'h104, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_BRANCH, OP_JAL, 5'd0, 5'd0, 32'h0, 32'h0, 32'h100, 32'h40, 1'b0, 1'b0);
        expect_out(32'h104, 32'h140, 1'b1, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);
        stim(UNIT_BRANCH, OP_JALR, 5'd1, 5'd0, 32'h2001, 32'h0, 32'h100, 32'h10, 1'b0, 1'b0);
        expect_out(32'h104, 32'h2010, 1'b1, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);

        // ----------------------------------------
        // Exception priority on a misaligned JALR
        // ----------------------------------------
        stim(UNIT_BRANCH, OP_JALR, 5'd1, 5'd0, 32'h2002, 32'h0, 32'h100, 32'h0, 1'b0, 1'b0);
        expect_out(32'h104, 32'h2002, 1'b1, 1'b1, CAUSE_INSTR_MISALIGNED, 32'h2002);
        stim(UNIT_BRANCH, OP_JALR, 5'd1, 5'd0, 32'h2002, 32'h0, 32'h100, 32'h0, 1'b0, 1'b0);
        r.irq = 1'b1;
        r.irq_cause = 4'd7;
        expect_out(32'h104, 32'h2002, 1'b1, 1'b1, 4'd7, 32'h0);
        stim(UNIT_BRANCH, OP_JALR, 5'd1, 5'd0, 32'h2002, 32'h0, 32'h100, 32'h0, 1'b0, 1'b0);
        r.irq = 1'b1;
        r.irq_cause = 4'd7;
        r.ex_valid = 1'b1;
        r.ex_cause = 4'd2;
        expect_out(32'h104, 32'h2002, 1'b1, 1'b1, 4'd2, 32'h0);

        // Killed multiply ahead of the full ones
        a = $random(seed);
        stim(UNIT_MUL, OP_MUL, 5'd5, 5'd6, a, 32'd3, 32'h0, 32'h0, 1'b0, 1'b0);
        r.kill_at = 8'd5;
        expect_out(32'h0, 32'h0, 1'b0, 1'b0, CAUSE_NONE_DEFAULT, 32'h0);

        // Random multiplies, expected halves from a full 64-bit product
        for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            b = $random(seed);
            prod = {32'd0, a} * {32'd0, b};
            stim(UNIT_MUL, (k % 2 == 0) ? OP_MUL : OP_MULHU, 5'd5, 5'd6, a, b,
                 32'h0, 32'h0, 1'b0, 1'b0);
            expect_out((k % 2 == 0) ? prod[31:0] : prod[63:32], 32'h0, 1'b0, 1'b0,
                       CAUSE_NONE_DEFAULT, 32'h0);
        end

        if (tbl.size() != N_ROWS) begin
            $display("Table holds %0d rows but the timeout assumes %0d", tbl.size(), N_ROWS);
            other_errors++;
        end

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #25;
        if (stall_o !== 1'b0 || valid_o !== 1'b0 || ex_valid_o !== 1'b0) begin
            $display("Outputs not idle after reset at time %0t", $time);
            other_errors++;
        end

        foreach (tbl[i]) begin
            @(negedge clk_i);
            apply_row(i, tbl[i]);
            #25;
            if (tbl[i].kill_at != 8'd0) begin
                if (stall_o !== 1'b1)
                    value_mismatch(i, "stall_o at start", 32'(stall_o), 32'd1);
                repeat (tbl[i].kill_at) @(negedge clk_i);
                kill_i = 1'b1;
                #25;
                if (stall_o !== 1'b0 || valid_o !== 1'b0)
                    value_mismatch(i, "stall_o/valid_o on kill", 32'({stall_o, valid_o}), 32'd0);
                @(negedge clk_i);
                kill_i = 1'b0;
                valid_i = 1'b0;
            end else begin
                stalls = 0;
                while (stall_o === 1'b1) begin   // Retire shows as stall dropping
                    stalls++;
                    @(negedge clk_i);
                    #25;
                end
                exp_stalls = (tbl[i].unit == UNIT_MUL) ? XLEN + 1 : 0;
                if (stalls != exp_stalls)
                    value_mismatch(i, "stall cycles", 32'(stalls), 32'(exp_stalls));
                check_outputs(i, tbl[i]);
            end
        end

        @(negedge clk_i);
        drive_idle();
        @(negedge clk_i);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/exe_stage_sva.sv */
// Execute stage assertions on stall, valid, kill release and exception pass-through
`default_nettype none

module exe_stage_sva import exe_pkg::*; (
    input logic   clk_i,
    input logic   rst_n_i,
    input logic   kill_i,
    input logic   valid_o,
    input logic   stall_o,
    input logic   ex_valid_i,
    input cause_t ex_cause_i,
    input cause_t ex_cause_o
);

    // ----------------------------------------
    // Handshake
    // ----------------------------------------
    valid_stall_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(valid_o && stall_o))
        else $error("valid_o and stall_o high together");

    // Multiplier is back in idle one cycle after kill
    kill_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        kill_i |=> !stall_o)
        else $error("stall_o still high after kill_i");

    upstream_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ex_valid_i |-> (ex_cause_o == ex_cause_i))
        else $error("upstream exception cause not passed through");

endmodule

bind exe_stage exe_stage_sva sva_i (.*);

`default_nettype wire

/* logic/exe_stage.sv */
// Execute stage top: operand select, ALU, multiplier, branch unit and write-back select
`default_nettype none

module exe_stage import exe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              kill_i,

    // From register read
    input  logic              valid_i,
    input  unit_t             unit_i,
    input  op_t               op_i,
    input  reg_addr_t         rs1_i,
    input  reg_addr_t         rs2_i,
    input  reg_addr_t         rd_i,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic              use_pc_i,
    input  logic              use_imm_i,
    input  logic              ex_valid_i,
    input  cause_t            ex_cause_i,

    // From write-back and CSR
    input  logic              wb_valid_i,
    input  reg_addr_t         wb_rd_i,
    input  logic [XLEN-1:0]   wb_data_i,
    input  logic              interrupt_i,
    input  cause_t            interrupt_cause_i,

    // To write-back
    output logic              valid_o,
    output reg_addr_t         rd_o,
    output logic [XLEN-1:0]   result_o,
    output logic [XLEN-1:0]   result_pc_o,
    output logic              branch_taken_o,
    output logic              ex_valid_o,
    output cause_t            ex_cause_o,
    output logic [XLEN-1:0]   ex_origin_o,
    output logic              stall_o
);

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mul_result;
    logic            mul_stall;
    logic            br_taken;
    logic [XLEN-1:0] br_next_pc;
    logic [XLEN-1:0] br_link;

    assign rd_o = rd_i;

    // ----------------------------------------
    // Input side
    // ----------------------------------------
    exe_operand_sel #(.XLEN(XLEN)) operand_sel_i (
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .wb_valid_i (wb_valid_i),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i),
        .pc_i       (pc_i),
        .imm_i      (imm_i),
        .use_pc_i   (use_pc_i),
        .use_imm_i  (use_imm_i),
        .rs1_fwd_o  (rs1_fwd),
        .rs2_fwd_o  (rs2_fwd),
        .op_a_o     (op_a),
        .op_b_o     (op_b)
    );

    // ----------------------------------------
    // Execution units
    // ----------------------------------------
    exe_alu #(.XLEN(XLEN)) alu_i (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .op_i     (op_i),
        .result_o (alu_result)
    );

    // Retire is seen through the stall dropping, done pulse left open
    exe_mul_unit #(.XLEN(XLEN)) mul_unit_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .kill_i   (kill_i),
        .valid_i  (valid_i),
        .unit_i   (unit_i),
        .op_i     (op_i),
        .src1_i   (rs1_fwd),
        .src2_i   (rs2_fwd),
        .result_o (mul_result),
        .stall_o  (mul_stall),
        .done_o   ()
    );

    exe_branch_unit #(.XLEN(XLEN)) branch_unit_i (
        .op_i      (op_i),
        .pc_i      (pc_i),
        .rs1_i     (rs1_fwd),
        .rs2_i     (rs2_fwd),
        .imm_i     (imm_i),
        .taken_o   (br_taken),
        .next_pc_o (br_next_pc),
        .link_o    (br_link)
    );

    // ----------------------------------------
    // Output side
    // ----------------------------------------
    exe_writeback_sel #(.XLEN(XLEN)) writeback_sel_i (
        .valid_i           (valid_i),
        .kill_i            (kill_i),
        .unit_i            (unit_i),
        .op_i              (op_i),
        .alu_result_i      (alu_result),
        .mul_result_i      (mul_result),
        .mul_stall_i       (mul_stall),
        .link_i            (br_link),
        .next_pc_i         (br_next_pc),
        .branch_taken_i    (br_taken),
        .rs1_fwd_i         (rs1_fwd),
        .ex_valid_i        (ex_valid_i),
        .ex_cause_i        (ex_cause_i),
        .interrupt_i       (interrupt_i),
        .interrupt_cause_i (interrupt_cause_i),
        .valid_o           (valid_o),
        .stall_o           (stall_o),
        .result_o          (result_o),
        .result_pc_o       (result_pc_o),
        .branch_taken_o    (branch_taken_o),
        .ex_valid_o        (ex_valid_o),
        .ex_cause_o        (ex_cause_o),
        .ex_origin_o       (ex_origin_o)
    );

endmodule

`default_nettype wire

/* logic/exe_writeback_sel.sv */
// Write-back side: result mux by unit, exception priority, stall and valid toward write-back
`default_nettype none

module exe_writeback_sel import exe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              valid_i,
    input  logic              kill_i,
    input  unit_t             unit_i,
    input  op_t               op_i,

    // Unit results
    input  logic [XLEN-1:0]   alu_result_i,
    input  logic [XLEN-1:0]   mul_result_i,
    input  logic              mul_stall_i,
    input  logic [XLEN-1:0]   link_i,
    input  logic [XLEN-1:0]   next_pc_i,
    input  logic              branch_taken_i,
    input  logic [XLEN-1:0]   rs1_fwd_i,

    // Exception sources
    input  logic              ex_valid_i,
    input  cause_t            ex_cause_i,
    input  logic              interrupt_i,
    input  cause_t            interrupt_cause_i,

    output logic              valid_o,
    output logic              stall_o,
    output logic [XLEN-1:0]   result_o,
    output logic [XLEN-1:0]   result_pc_o,
    output logic              branch_taken_o,
    output logic              ex_valid_o,
    output cause_t            ex_cause_o,
    output logic [XLEN-1:0]   ex_origin_o
);

    logic jalr_misaligned;

    // ----------------------------------------
    // Result mux
    // ----------------------------------------
    always_comb begin
        result_pc_o    = '0;
        branch_taken_o = 1'b0;
        case (unit_i)
            UNIT_ALU:    result_o = alu_result_i;
            UNIT_MUL:    result_o = mul_result_i;
            UNIT_BRANCH: begin
                result_o       = link_i;
                result_pc_o    = next_pc_i;
                branch_taken_o = branch_taken_i;
            end
            UNIT_SYSTEM: result_o = rs1_fwd_i;
            default:     result_o = '0;
        endcase
    end

    // JALR is always taken, so next PC is its target
    assign jalr_misaligned = (unit_i == UNIT_BRANCH) && (op_i == OP_JALR)
                             && (next_pc_i[1:0] != 2'b00);

    // ----------------------------------------
    // Exceptions
    // ----------------------------------------
    always_comb begin
        ex_valid_o  = 1'b0;
        ex_cause_o  = CAUSE_NONE_DEFAULT;
        ex_origin_o = '0;
        if (ex_valid_i) begin   // Earlier stage wins
            ex_valid_o = 1'b1;
            ex_cause_o = ex_cause_i;
        end else if (valid_i) begin
            if (interrupt_i) begin
                ex_valid_o = 1'b1;
                ex_cause_o = interrupt_cause_i;
            end else if (jalr_misaligned) begin
                ex_valid_o  = 1'b1;
                ex_cause_o  = CAUSE_INSTR_MISALIGNED;
                ex_origin_o = next_pc_i;
            end
        end
    end

    // Only a valid MUL holds the pipe, kill releases it at once
    assign stall_o = valid_i && (unit_i == UNIT_MUL) && mul_stall_i && !kill_i;
    assign valid_o = valid_i && !stall_o && !kill_i;

endmodule

`default_nettype wire

/* logic/exe_branch_unit.sv */
// Branch unit: condition compare, jump target, next PC and link value
`default_nettype none

module exe_branch_unit import exe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  op_t               op_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   rs1_i,
    input  logic [XLEN-1:0]   rs2_i,
    input  logic [XLEN-1:0]   imm_i,
    output logic              taken_o,
    output logic [XLEN-1:0]   next_pc_o,
    output logic [XLEN-1:0]   link_o
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;
    logic            eq;
    logic            lt;

    assign pc_plus4 = pc_i + XLEN'(4);
    assign jalr_sum = rs1_i + imm_i;

    assign eq = (rs1_i == rs2_i);
    assign lt = $signed(rs1_i) < $signed(rs2_i);

    // ----------------------------------------
    // Condition
    // ----------------------------------------
    always_comb begin
        case (op_i)
            OP_BEQ:  taken_o = eq;
            OP_BNE:  taken_o = !eq;
            OP_BLT:  taken_o = lt;
            OP_BGE:  taken_o = !lt;
            OP_JAL,
            OP_JALR: taken_o = 1'b1;    // Jumps always go
            default: taken_o = 1'b0;
        endcase
    end

    // JALR drops bit 0, bit 1 is left for the misalign check
    assign target = (op_i == OP_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign next_pc_o = taken_o ? target : pc_plus4;
    assign link_o    = pc_plus4;

endmodule

`default_nettype wire

/* logic/exe_mul_unit.sv */
// Bit-serial shift-and-add multiplier, stalls the pipe for XLEN+1 cycles, abortable by kill
`default_nettype none

module exe_mul_unit import exe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              kill_i,
    input  logic              valid_i,
    input  unit_t             unit_i,
    input  op_t               op_i,
    input  logic [XLEN-1:0]   src1_i,
    input  logic [XLEN-1:0]   src2_i,
    output logic [XLEN-1:0]   result_o,
    output logic              stall_o,
    output logic              done_o
);

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } mul_state_t;

    mul_state_t        state_q;
    mul_state_t        state_d;
    logic [CNT_W-1:0]  count_q;
    logic [XLEN-1:0]   mcand_q;
    logic [2*XLEN-1:0] acc_q;   // High half partial sum, low half multiplier
    logic [XLEN:0]     partial;
    logic              start;

    assign start = valid_i && (unit_i == UNIT_MUL);

    // Add multiplicand when the current multiplier bit is set
    assign partial = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, mcand_q & {XLEN{acc_q[0]}}};

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start) state_d = BUSY;
            BUSY: if (count_q == CNT_W'(XLEN-1)) state_d = DONE;
            DONE: state_d = IDLE;   // No re-trigger on the done cycle
            default: state_d = IDLE;
        endcase
        if (kill_i) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == BUSY) begin
                count_q <= count_q + 1'b1;
            end else begin
                count_q <= '0;
            end
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start) begin
            mcand_q <= src1_i;
            acc_q   <= {{XLEN{1'b0}}, src2_i};
        end else if (state_q == BUSY) begin
            acc_q <= {partial, acc_q[XLEN-1:1]};  // One bit per cycle
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign stall_o  = ((state_q == IDLE && start) || state_q == BUSY) && !kill_i;
    assign done_o   = (state_q == DONE);
    assign result_o = !done_o            ? '0 :
                      (op_i == OP_MULHU) ? acc_q[2*XLEN-1:XLEN] :
                                           acc_q[XLEN-1:0];

endmodule

`default_nettype wire

/* logic/exe_alu.sv */
// Single-cycle integer ALU: add/sub, logic, shifts and set-less-than
`default_nettype none

module exe_alu import exe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]   op_a_i,
    input  logic [XLEN-1:0]   op_b_i,
    input  op_t               op_i,
    output logic [XLEN-1:0]   result_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;
    logic           lt_signed;
    logic           lt_unsigned;

    assign shamt       = op_b_i[SHW-1:0];  // Upper bits ignored as in RV
    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    // ----------------------------------------
    // Operation decode
    // ----------------------------------------
    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = op_a_i + op_b_i;
            end
            OP_SUB: begin
                result_o = op_a_i - op_b_i;
            end
            OP_AND: begin
                result_o = op_a_i & op_b_i;
            end
            OP_OR: begin
                result_o = op_a_i | op_b_i;
            end
            OP_XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            OP_SLL: begin
                result_o = op_a_i << shamt;
            end
            OP_SRL: begin
                result_o = op_a_i >> shamt;
            end
            OP_SRA: begin
                result_o = $unsigned($signed(op_a_i) >>> shamt);  // Sign fill
            end
            OP_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            OP_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/exe_operand_sel.sv */
// Operand select: write-back forwarding into rs1/rs2, then PC and immediate substitution
`default_nettype none

module exe_operand_sel import exe_pkg::*; #(
    parameter int XLEN = 32
) (
    input  reg_addr_t         rs1_i,
    input  reg_addr_t         rs2_i,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,

    // Write-back bypass
    input  logic              wb_valid_i,
    input  reg_addr_t         wb_rd_i,
    input  logic [XLEN-1:0]   wb_data_i,

    // Substitution controls
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic              use_pc_i,
    input  logic              use_imm_i,

    output logic [XLEN-1:0]   rs1_fwd_o,
    output logic [XLEN-1:0]   rs2_fwd_o,
    output logic [XLEN-1:0]   op_a_o,
    output logic [XLEN-1:0]   op_b_o
);

    logic hit_rs1;
    logic hit_rs2;

    // ----------------------------------------
    // Bypass match
    // ----------------------------------------
    // x0 never forwards, even if write-back targets it
    assign hit_rs1 = wb_valid_i && (rs1_i != '0) && (rs1_i == wb_rd_i);
    assign hit_rs2 = wb_valid_i && (rs2_i != '0) && (rs2_i == wb_rd_i);

    assign rs1_fwd_o = hit_rs1 ? wb_data_i : rs1_data_i;
    assign rs2_fwd_o = hit_rs2 ? wb_data_i : rs2_data_i;

    // ----------------------------------------
    // ALU operands
    // ----------------------------------------
    assign op_a_o = use_pc_i  ? pc_i  : rs1_fwd_o;  // AUIPC style
    assign op_b_o = use_imm_i ? imm_i : rs2_fwd_o;  // I-type

endmodule

`default_nettype wire

/* logic/exe_pkg.sv */
// Execute stage shared types: register index, unit select, op codes, exception causes
`default_nettype none

package exe_pkg;

    // ----------------------------------------
    // Basic widths
    // ----------------------------------------
    typedef logic [4:0] reg_addr_t;  // Architectural register, x0 hard zero
    typedef logic [2:0] unit_t;      // Execution unit select
    typedef logic [3:0] op_t;        // Operation, decoded within the unit
    typedef logic [3:0] cause_t;     // Exception cause

    // Unit encodings
    localparam unit_t UNIT_ALU    = 3'd0;
    localparam unit_t UNIT_MUL    = 3'd1;
    localparam unit_t UNIT_BRANCH = 3'd2;
    localparam unit_t UNIT_SYSTEM = 3'd3;  // Forwarded rs1 goes straight to result

    // ----------------------------------------
    // Operation codes
    // ----------------------------------------
    localparam op_t OP_ADD  = 4'd0;
    localparam op_t OP_SUB  = 4'd1;
    localparam op_t OP_AND  = 4'd2;
    localparam op_t OP_OR   = 4'd3;
    localparam op_t OP_XOR  = 4'd4;
    localparam op_t OP_SLL  = 4'd5;
    localparam op_t OP_SRL  = 4'd6;
    localparam op_t OP_SRA  = 4'd7;
    localparam op_t OP_SLT  = 4'd8;
    localparam op_t OP_SLTU = 4'd9;

    // Branch group sits above the ALU codes
    localparam op_t OP_BEQ  = 4'd10;
    localparam op_t OP_BNE  = 4'd11;
    localparam op_t OP_BLT  = 4'd12;
    localparam op_t OP_BGE  = 4'd13;
    localparam op_t OP_JAL  = 4'd14;
    localparam op_t OP_JALR = 4'd15;

    // Multiplier reuses the low codes
    localparam op_t OP_MUL   = 4'd0;  // Low half of product
    localparam op_t OP_MULHU = 4'd1;  // High half, unsigned

    // Exception causes
    localparam cause_t CAUSE_INSTR_MISALIGNED = 4'd0;
    localparam cause_t CAUSE_NONE_DEFAULT     = 4'd0;

endpackage

`default_nettype wire
